//--- icache.f
+incdir+include
src/icache_pkg.sv
src/icache_ctrl.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_fifo_repl.sv
src/icache_top.sv
test/icache_assertions.sv
test/icache_tb.sv

//--- include/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// ====================
// Cache geometry
// ====================

// Address and instruction width
`define ICACHE_XLEN        32
// One line holds four 32-bit words
`define ICACHE_LINE_BITS   128
`define ICACHE_N_WAYS      4
`define ICACHE_N_SETS      16

// ====================
// Address split
// ====================

// Byte offset inside a word
`define ICACHE_BYTE_BITS   2
// Word offset inside a line
`define ICACHE_WORD_BITS   2
// Set index
`define ICACHE_INDEX_BITS  4
// Whatever is left of the address above the index
`define ICACHE_TAG_BITS    24

`endif

//--- run.sh
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
    -f icache.f -o icache_sim || { echo "Build failed"; exit 1; }
./obj_dir/icache_sim > sim.log 2>&1
cat sim.log
grep -q "^TEST PASSED$" sim.log && exit 0 || exit 1

//--- src/icache_ctrl.sv
`include "icache_config.svh"

module icache_ctrl
(
    input  logic               clk_i,
    input  logic               rst_i,
    // Processor side
    input  logic               p_strobe_i,
    input  icache_pkg::word_t  line_addr_i,
    // From the tag array
    input  logic               hit_i,
    // Memory side
    input  logic               m_ready_i,
    // Control outputs
    output logic               ready_o,
    output logic               fill_we_o,
    output logic               init_clr_o,
    output icache_pkg::index_t init_index_o,
    output logic               m_strobe_o,
    output icache_pkg::word_t  m_addr_o
);

    icache_pkg::ctrl_state_e state_q;
    icache_pkg::ctrl_state_e state_d;

    // Walks the sets once after reset
    icache_pkg::index_t init_cnt_q;
    logic               init_last;

    // Lookup found no matching way
    logic               miss;

    assign init_last = (init_cnt_q == icache_pkg::index_t'(`ICACHE_N_SETS - 1));
    assign miss      = (state_q == icache_pkg::ST_LOOKUP) && !hit_i;

    // ====================
    // State register
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= icache_pkg::ST_INIT;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            icache_pkg::ST_INIT:
            begin
                // Cache is usable once the last set is cleared
                if (init_last)
                begin
                    state_d = icache_pkg::ST_IDLE;
                end
            end
            icache_pkg::ST_IDLE:
            begin
                if (p_strobe_i)
                begin
                    state_d = icache_pkg::ST_LOOKUP;
                end
            end
            icache_pkg::ST_LOOKUP:
            begin
                // Hit is answered in this cycle and a miss goes to memory
                state_d = hit_i ? icache_pkg::ST_IDLE : icache_pkg::ST_REFILL;
            end
            icache_pkg::ST_REFILL:
            begin
                if (m_ready_i)
                begin
                    state_d = icache_pkg::ST_IDLE;
                end
            end
            default:
            begin
                state_d = icache_pkg::ST_INIT;
            end
        endcase
    end

    // ====================
    // Valid clear counter
    // ====================

    // One set per cycle until the last set
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            init_cnt_q <= '0;
        end
        else if (state_q == icache_pkg::ST_INIT && !init_last)
        begin
            init_cnt_q <= init_cnt_q + 1'b1;
        end
    end

    assign init_clr_o   = (state_q == icache_pkg::ST_INIT);
    assign init_index_o = init_cnt_q;

    // ====================
    // Memory request
    // ====================

    // Strobe rises once when the miss is found and the state then leaves lookup
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
        end
        else
        begin
            m_strobe_o <= miss;
        end
    end

    // Line address is held for the whole refill and is zero otherwise
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_addr_o <= '0;
        end
        else if (miss)
        begin
            m_addr_o <= line_addr_i;
        end
        else if (fill_we_o)
        begin
            m_addr_o <= '0;
        end
    end

    // Incoming line is written while the processor gets its word
    assign fill_we_o = (state_q == icache_pkg::ST_REFILL) && m_ready_i;
    assign ready_o   = ((state_q == icache_pkg::ST_LOOKUP) && hit_i) || fill_we_o;

endmodule

//--- src/icache_data_array.sv
`include "icache_config.svh"

module icache_data_array
(
    input  logic                 clk_i,
    input  icache_pkg::index_t   index_i,
    input  icache_pkg::offset_t  offset_i,
    // Way that matched in the tag array
    input  icache_pkg::way_t     hit_way_i,
    // Fill port
    input  icache_pkg::way_t     victim_way_i,
    input  logic                 fill_we_i,
    input  icache_pkg::line_t    m_data_i,
    // Selected instruction
    output icache_pkg::word_t    data_o
);

    localparam int WORDS = `ICACHE_LINE_BITS / `ICACHE_XLEN;

    // One line memory per way
    icache_pkg::line_t mem_q     [`ICACHE_N_WAYS][`ICACHE_N_SETS];
    // Registered read of every way
    icache_pkg::line_t rd_line_q [`ICACHE_N_WAYS];
    icache_pkg::line_t sel_line;

    // ====================
    // Line storage
    // ====================

    // Synchronous read with the line one cycle after the index
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < `ICACHE_N_WAYS; w++)
        begin
            if (fill_we_i && (victim_way_i == icache_pkg::way_t'(w)))
            begin
                mem_q[w][index_i] <= m_data_i;
            end
            rd_line_q[w] <= mem_q[w][index_i];
        end
    end

    // ====================
    // Word select
    // ====================

    // Refill returns the word straight from the incoming line
    assign sel_line = fill_we_i ? m_data_i : rd_line_q[hit_way_i];

    // Word 0 sits in the top bits of the line
    assign data_o = sel_line[(WORDS - 1 - int'(offset_i)) * `ICACHE_XLEN +: `ICACHE_XLEN];

endmodule

//--- src/icache_fifo_repl.sv
`include "icache_config.svh"

module icache_fifo_repl
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  icache_pkg::index_t   index_i,
    input  logic                 fill_we_i,
    output icache_pkg::way_t     victim_way_o
);

    // Next way to replace with one counter per set
    icache_pkg::way_t fifo_cnt_q [`ICACHE_N_SETS];

    // Counter wraps through the ways in fill order
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < `ICACHE_N_SETS; s++)
            begin
                fifo_cnt_q[s] <= '0;
            end
        end
        else if (fill_we_i)
        begin
            fifo_cnt_q[index_i] <= fifo_cnt_q[index_i] + 1'b1;
        end
    end

    // Combinational read for the indexed set
    assign victim_way_o = fifo_cnt_q[index_i];

endmodule

//--- src/icache_pkg.sv
`include "icache_config.svh"

package icache_pkg;

    // ====================
    // Width types
    // ====================

    // Instruction word or byte address
    typedef logic [`ICACHE_XLEN-1:0]        word_t;
    // Full cache line with word 0 in the top bits
    typedef logic [`ICACHE_LINE_BITS-1:0]   line_t;
    typedef logic [`ICACHE_TAG_BITS-1:0]    tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0]  index_t;
    // Word position inside a line
    typedef logic [`ICACHE_WORD_BITS-1:0]   offset_t;
    // Way number and one-hot way mask
    typedef logic [1:0]                     way_t;
    typedef logic [`ICACHE_N_WAYS-1:0]      way_mask_t;

    // ====================
    // Controller states
    // ====================
    typedef enum logic [2:0]
    {
        ST_INIT   = 3'd0,  // Valid bits being cleared
        ST_IDLE   = 3'd1,  // Waiting for a fetch strobe
        ST_LOOKUP = 3'd2,  // Tag compare and hit answer
        ST_REFILL = 3'd3   // Waiting for the memory line
    } ctrl_state_e;

endpackage

//--- src/icache_tag_array.sv
`include "icache_config.svh"

module icache_tag_array
(
    input  logic                 clk_i,
    // Lookup and fill address
    input  icache_pkg::index_t   index_i,
    input  icache_pkg::tag_t     tag_i,
    // Fill port
    input  logic                 fill_we_i,
    input  icache_pkg::way_t     victim_way_i,
    // Valid clear after reset
    input  logic                 init_clr_i,
    input  icache_pkg::index_t   init_index_i,
    // Lookup result
    output logic                 hit_o,
    output icache_pkg::way_t     hit_way_o
);

    // Per-way valid bits and tags with one entry per set
    logic               valid_q [`ICACHE_N_WAYS][`ICACHE_N_SETS];
    icache_pkg::tag_t   tag_q   [`ICACHE_N_WAYS][`ICACHE_N_SETS];

    // One bit per matching way
    icache_pkg::way_mask_t hit_mask;

    // ====================
    // Storage update
    // ====================
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < `ICACHE_N_WAYS; w++)
        begin
            if (init_clr_i)
            begin
                // All ways of one set at a time
                valid_q[w][init_index_i] <= 1'b0;
            end
            else if (fill_we_i && (victim_way_i == icache_pkg::way_t'(w)))
            begin
                valid_q[w][index_i] <= 1'b1;
                tag_q[w][index_i]   <= tag_i;
            end
        end
    end

    // ====================
    // Tag compare
    // ====================

    // Asynchronous read so the result is ready in the lookup cycle
    always_comb
    begin
        for (int w = 0; w < `ICACHE_N_WAYS; w++)
        begin
            hit_mask[w] = valid_q[w][index_i] && (tag_q[w][index_i] == tag_i);
        end
    end

    assign hit_o = |hit_mask;

    // Mask to way number
    // Scan from the top so the lowest way wins on a multi-hit
    always_comb
    begin
        hit_way_o = '0;
        for (int w = `ICACHE_N_WAYS - 1; w >= 0; w--)
        begin
            if (hit_mask[w])
            begin
                hit_way_o = icache_pkg::way_t'(w);
            end
        end
    end

endmodule

//--- src/icache_top.sv
`include "icache_config.svh"

module icache_top
(
    input  logic               clk_i,
    input  logic               rst_i,
    // Processor side
    input  logic               p_strobe_i,
    input  icache_pkg::word_t  p_addr_i,
    output logic               p_ready_o,
    output icache_pkg::word_t  p_data_o,
    // Memory side
    output logic               m_strobe_o,
    output icache_pkg::word_t  m_addr_o,
    input  icache_pkg::line_t  m_data_i,
    input  logic               m_ready_i
);

    // Low bit of each address field
    localparam int OFFSET_LSB = `ICACHE_BYTE_BITS;
    localparam int INDEX_LSB  = OFFSET_LSB + `ICACHE_WORD_BITS;
    localparam int TAG_LSB    = INDEX_LSB + `ICACHE_INDEX_BITS;

    // ====================
    // Address split
    // ====================
    icache_pkg::tag_t    addr_tag;
    icache_pkg::index_t  addr_index;
    icache_pkg::offset_t addr_offset;
    icache_pkg::word_t   line_addr;

    assign addr_tag    = p_addr_i[`ICACHE_XLEN-1:TAG_LSB];
    assign addr_index  = p_addr_i[TAG_LSB-1:INDEX_LSB];
    assign addr_offset = p_addr_i[INDEX_LSB-1:OFFSET_LSB];
    // Word and byte bits cleared for the memory request
    assign line_addr   = {p_addr_i[`ICACHE_XLEN-1:INDEX_LSB], {INDEX_LSB{1'b0}}};

    // Internal wiring
    logic               hit;
    icache_pkg::way_t   hit_way;
    icache_pkg::way_t   victim_way;
    logic               fill_we;
    logic               init_clr;
    icache_pkg::index_t init_index;

    // ====================
    // Blocks
    // ====================
    icache_ctrl u_ctrl
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .p_strobe_i   (p_strobe_i),
        .line_addr_i  (line_addr),
        .hit_i        (hit),
        .m_ready_i    (m_ready_i),
        .ready_o      (p_ready_o),
        .fill_we_o    (fill_we),
        .init_clr_o   (init_clr),
        .init_index_o (init_index),
        .m_strobe_o   (m_strobe_o),
        .m_addr_o     (m_addr_o)
    );

    icache_tag_array u_tag_array
    (
        .clk_i        (clk_i),
        .index_i      (addr_index),
        .tag_i        (addr_tag),
        .fill_we_i    (fill_we),
        .victim_way_i (victim_way),
        .init_clr_i   (init_clr),
        .init_index_i (init_index),
        .hit_o        (hit),
        .hit_way_o    (hit_way)
    );

    icache_data_array u_data_array
    (
        .clk_i        (clk_i),
        .index_i      (addr_index),
        .offset_i     (addr_offset),
        .hit_way_i    (hit_way),
        .victim_way_i (victim_way),
        .fill_we_i    (fill_we),
        .m_data_i     (m_data_i),
        .data_o       (p_data_o)
    );

    // Victim choice for the set being looked up
    icache_fifo_repl u_fifo_repl
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .index_i      (addr_index),
        .fill_we_i    (fill_we),
        .victim_way_o (victim_way)
    );

endmodule

//--- test/icache_assertions.sv
module icache_assertions
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              p_ready_i,
    input  logic              m_strobe_i,
    input  icache_pkg::word_t m_addr_i
);

    // ====================
    // Processor side
    // ====================

    // Ready is a single-cycle pulse
    ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_i |=> !p_ready_i)
        else $error("p_ready_o high on two consecutive cycles");

    // ====================
    // Memory side
    // ====================
    strobe_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_i |=> !m_strobe_i)
        else $error("m_strobe_o longer than one cycle");

    // Request and answer never overlap
    strobe_ready_apart: assert property (@(posedge clk_i) disable iff (rst_i)
        !(m_strobe_i && p_ready_i))
        else $error("m_strobe_o and p_ready_o high together");

    // Line-aligned request address
    addr_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_i |-> (m_addr_i[3:0] == 4'h0))
        else $error("m_addr_o not line aligned");

endmodule

//--- test/icache_tb.sv
`include "icache_config.svh"

module icache_tb;

    // ====================
    // Test sizes
    // ====================
    localparam int TABLE_LEN = 20;
    localparam int N_RAND    = 24;
    // Every access is counted, plus reset, init and the settle wait
    localparam int TIMEOUT_CYCLES = (TABLE_LEN + N_RAND) * 10 + 40;
    localparam logic [15:0] LFSR_SEED = 16'd47054;
    // Word at byte address a holds a ^ WORD_KEY
    localparam logic [31:0] WORD_KEY  = 32'hC0DE0000;

    // Stimulus table entries are {expected hit, word address}
    localparam logic [32:0] STIM [TABLE_LEN] = '{
        // Cold miss followed by hits on all four words of the line
        {1'b0, 32'h0000_1004}, {1'b1, 32'h0000_1004}, {1'b1, 32'h0000_1000},
        {1'b1, 32'h0000_1008}, {1'b1, 32'h0000_100C},
        // Four tags into set 3
        {1'b0, 32'h0000_2030}, {1'b0, 32'h0000_3034}, {1'b0, 32'h0000_4038},
        {1'b0, 32'h0000_503C},
        // Set 0 untouched and all of set 3 resident
        {1'b1, 32'h0000_1004}, {1'b1, 32'h0000_2030}, {1'b1, 32'h0000_3030},
        {1'b1, 32'h0000_4030}, {1'b1, 32'h0000_5030},
        // Fifth tag evicts the oldest and the refetch evicts the next one
        {1'b0, 32'h0000_6030}, {1'b0, 32'h0000_2030}, {1'b1, 32'h0000_4030},
        {1'b1, 32'h0000_5034}, {1'b0, 32'h0000_3038}, {1'b0, 32'h0000_4030}
    };

    // DUT signals
    logic              clk_i;
    logic              rst_i;
    logic              p_strobe_i;
    icache_pkg::word_t p_addr_i;
    logic              p_ready_o;
    icache_pkg::word_t p_data_o;
    logic              m_strobe_o;
    icache_pkg::word_t m_addr_o;
    icache_pkg::line_t m_data_i;
    logic              m_ready_i;

    // Reference model of tags and FIFO pointers
    logic        ref_valid [`ICACHE_N_SETS][`ICACHE_N_WAYS];
    logic [23:0] ref_tag   [`ICACHE_N_SETS][`ICACHE_N_WAYS];
    logic [1:0]  ref_ptr   [`ICACHE_N_SETS];

    logic [15:0] lfsr_q;
    logic [31:0] rand_addr [N_RAND];
    logic [31:0] rnd;
    int          mem_delay;
    int          errors;
    int          checks;
    int          cycle_cnt = 0;

    icache_top u_icache_top
    (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .p_strobe_i (p_strobe_i),
        .p_addr_i   (p_addr_i),
        .p_ready_o  (p_ready_o),
        .p_data_o   (p_data_o),
        .m_strobe_o (m_strobe_o),
        .m_addr_o   (m_addr_o),
        .m_data_i   (m_data_i),
        .m_ready_i  (m_ready_i)
    );

    bind icache_top icache_assertions u_assertions
    (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .p_ready_i  (p_ready_o),
        .m_strobe_i (m_strobe_o),
        .m_addr_i   (m_addr_o)
    );

    always #50 clk_i = ~clk_i;

    // ====================
    // Helpers
    // ====================

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    // Word 0 at the lowest address goes into the top 32 bits
    function automatic icache_pkg::line_t build_line(input logic [31:0] line_addr);
        icache_pkg::line_t line;
        for (int k = 0; k < 4; k++)
        begin
            line[(3 - k) * 32 +: 32] = (line_addr + 32'(4 * k)) ^ WORD_KEY;
        end
        return line;
    endfunction

    // Set index sits in bits 7:4 with the tag above
    function automatic logic model_hit(input logic [31:0] addr);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < `ICACHE_N_WAYS; w++)
        begin
            if (ref_valid[addr[7:4]][w] && ref_tag[addr[7:4]][w] == addr[31:8])
            begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic model_fill(input logic [31:0] addr);
        ref_valid[addr[7:4]][ref_ptr[addr[7:4]]] = 1'b1;
        ref_tag[addr[7:4]][ref_ptr[addr[7:4]]]   = addr[31:8];
        ref_ptr[addr[7:4]] = ref_ptr[addr[7:4]] + 2'd1;
    endtask

    // One fetch checked against the model and the memory rule
    task automatic run_access(input logic [31:0] addr);
        int          cycles;
        int          strobes;
        logic        pred_hit;
        logic [31:0] exp_data;
        pred_hit = model_hit(addr);
        exp_data = addr ^ WORD_KEY;
        cycles   = 0;
        strobes  = 0;
        // Strobe only in idle
        @(negedge clk_i);
        while (u_icache_top.u_ctrl.state_q != icache_pkg::ST_IDLE)
        begin
            @(negedge clk_i);
        end
        p_addr_i   = addr;
        p_strobe_i = 1'b1;
        @(negedge clk_i);
        p_strobe_i = 1'b0;
        do
        begin
            @(posedge clk_i);
            cycles++;
            if (m_strobe_o)
            begin
                strobes++;
                checks++;
                if (m_addr_o !== {addr[31:4], 4'h0})
                begin
                    $display("CHECK FAILED m_addr_o exp=%h got=%h", {addr[31:4], 4'h0},
                             m_addr_o);
                    errors++;
                end
            end
        end
        while (!p_ready_o);
        checks += 2;
        if (strobes != (pred_hit ? 0 : 1))
        begin
            $display("CHECK FAILED m_strobe_o count addr=%h exp=%h got=%h", addr,
                     pred_hit ? 0 : 1, strobes);
            errors++;
        end
        if (p_data_o !== exp_data)
        begin
            $display("CHECK FAILED p_data_o addr=%h exp=%h got=%h", addr, exp_data,
                     p_data_o);
            errors++;
        end
        if (pred_hit)
        begin
            checks++;
            // Hit answers in the lookup cycle
            if (cycles != 1)
            begin
                $display("CHECK FAILED p_ready_o latency addr=%h exp=%h got=%h", addr, 1,
                         cycles);
                errors++;
            end
        end
        else
        begin
            model_fill(addr);
        end
    endtask

    // ====================
    // Memory model
    // ====================
    initial
    begin
        m_ready_i = 1'b0;
        m_data_i  = '0;
        mem_delay = 0;
        forever
        begin
            @(negedge clk_i);
            m_ready_i = 1'b0;
            if (mem_delay > 0)
            begin
                mem_delay--;
                if (mem_delay == 0)
                begin
                    m_data_i  = build_line(m_addr_o);
                    m_ready_i = 1'b1;
                end
            end
            else if (m_strobe_o)
            begin
                // Answer 1 to 4 cycles later
                take_bits(2, rnd);
                mem_delay = int'(rnd) + 1;
            end
        end
    end

    // Run limit
    always @(posedge clk_i)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, errors so far: %0d", cycle_cnt, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ====================
    // Main sequence
    // ====================
    initial
    begin
        logic [31:0] bits;
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        p_strobe_i = 1'b0;
        p_addr_i   = '0;
        lfsr_q     = LFSR_SEED;
        errors     = 0;
        checks     = 0;
        for (int s = 0; s < `ICACHE_N_SETS; s++)
        begin
            ref_ptr[s] = '0;
            for (int w = 0; w < `ICACHE_N_WAYS; w++)
            begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
        // Random fetches over tags 0..7 and sets 0..3 at any word
        for (int i = 0; i < N_RAND; i++)
        begin
            take_bits(7, bits);
            rand_addr[i] = {21'd0, bits[6:4], 2'b00, bits[3:2], bits[1:0], 2'b00};
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        // Valid clear runs meanwhile
        repeat (20) @(negedge clk_i);
        for (int i = 0; i < TABLE_LEN; i++)
        begin
            // Table flag against the model before the fetch updates it
            if (STIM[i][32] !== model_hit(STIM[i][31:0]))
            begin
                $display("Table expects hit=%0d at %h but the model predicts %0d",
                         STIM[i][32], STIM[i][31:0], model_hit(STIM[i][31:0]));
                errors++;
            end
            run_access(STIM[i][31:0]);
        end
        for (int i = 0; i < N_RAND; i++)
        begin
            run_access(rand_addr[i]);
        end
        @(negedge clk_i);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
